/* verilog/debug_defs.svh */
`ifndef DEBUG_DEFS_SVH
`define DEBUG_DEFS_SVH

// machine word and memory geometry
`define DBG_NB_BITS    32                      // data word width
`define DBG_RAM_DEPTH  10                      // ram address bits, 1024 words
`define DBG_HALT_WORD  {`DBG_NB_BITS{1'b1}}    // all ones stops a run

// command word layout, as the host presents it
`define DBG_BIT_WE     22                      // write held data to memory
`define DBG_BIT_CLR    21                      // clear cycle count, strobe only

`define DBG_CTL_HI     24                      // run control field
`define DBG_CTL_LO     23

`define DBG_FLD_HI     20                      // field select
`define DBG_FLD_LO     19

`define DBG_RD_HI      17                      // readback select
`define DBG_RD_LO      16

`define DBG_PAY_HI     15                      // half word payload
`define DBG_PAY_LO     0

`endif

/* verilog/debug_cmd_pkg.sv */
`include "debug_defs.svh"

package debug_cmd_pkg;

	// raw word from the spi slave
	typedef logic [`DBG_NB_BITS-1:0] cmd_word_t;

	// bits 20:19, what the payload loads into
	typedef enum logic [1:0] {
		FLD_NONE = 2'b00,   // memory op or nothing
		FLD_LO   = 2'b01,   // low half of data
		FLD_HI   = 2'b10,   // upper half of data
		FLD_ADDR = 2'b11    // ram address
	} field_sel_t;

	// bits 17:16, which probe goes back to the host
	typedef enum logic [1:0] {
		RD_PC         = 2'b00,   // live pc
		RD_PC_LATCH   = 2'b01,   // pc of last fetch
		RD_INST_LATCH = 2'b10,   // word of last fetch
		RD_CYCLES     = 2'b11    // advance count
	} rd_sel_t;

	// bits 24:23, only looked at on the strobe
	typedef enum logic [1:0] {
		CTL_NONE = 2'b00,
		CTL_RUN  = 2'b01,   // free run until halt word
		CTL_STEP = 2'b10,   // single advance
		CTL_HALT = 2'b11    // stop at next edge
	} run_ctl_t;

endpackage

/* verilog/debug_core_pkg.sv */
`include "debug_defs.svh"

package debug_core_pkg;

	typedef logic [`DBG_NB_BITS-1:0]   word_t;       // machine word
	typedef logic [`DBG_RAM_DEPTH-1:0] ram_addr_t;   // program memory index

	// fetch latch, instruction up top and pc below
	typedef logic [2*`DBG_NB_BITS-1:0] latch_t;

	// control fsm states
	typedef enum logic [1:0] {
		HALTED = 2'b00,   // host owns memory
		RUN    = 2'b01,   // advance every cycle
		STEP   = 2'b10    // one advance then back
	} ctrl_state_t;

endpackage

/* verilog/debug_probe_if.sv */
`timescale 1ns/1ps

// loader to fetch stage link, ram write port one way and probes the other
interface debug_probe_if;

	debug_core_pkg::ram_addr_t ram_addr;   // held write address
	debug_core_pkg::word_t     ram_data;   // assembled write data
	logic                      ram_we;     // gated write strobe
	debug_core_pkg::word_t     pc;         // live pc
	debug_core_pkg::latch_t    latch;      // {inst, pc} of last advance

	modport loader (
		output ram_addr,
		output ram_data,
		output ram_we,
		input  pc,
		input  latch
	);

	modport target (
		input  ram_addr,
		input  ram_data,
		input  ram_we,
		output pc,
		output latch
	);

endinterface

/* verilog/spi_fetch_interface.sv */
`timescale 1ns/1ps

`include "debug_defs.svh"

module spi_fetch_interface (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  debug_cmd_pkg::cmd_word_t  i_cmd,      // word from the spi slave
	input  logic                      i_in_use,   // high while the core is halted
	input  debug_core_pkg::word_t     i_cycles,   // from cycle counter
	debug_probe_if.loader             probe,
	output debug_core_pkg::word_t     o_rd_data   // back to the spi slave
);

	localparam int HALF = `DBG_NB_BITS / 2;   // half word split point

	debug_core_pkg::ram_addr_t addr_q;   // held ram address
	debug_core_pkg::word_t     data_q;   // assembled data word
	debug_cmd_pkg::field_sel_t fld_sel;
	debug_cmd_pkg::rd_sel_t    rd_sel;
	logic [HALF-1:0]           payload;

	assign fld_sel = debug_cmd_pkg::field_sel_t'(i_cmd[`DBG_FLD_HI:`DBG_FLD_LO]);
	assign rd_sel  = debug_cmd_pkg::rd_sel_t'(i_cmd[`DBG_RD_HI:`DBG_RD_LO]);
	assign payload = i_cmd[`DBG_PAY_HI:`DBG_PAY_LO];

	// a field load repeats on every edge the code is held
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			addr_q <= '0;
			data_q <= '0;
		end else begin
			case (fld_sel)
				debug_cmd_pkg::FLD_LO: begin
					data_q[HALF-1:0] <= payload;   // low half only
				end
				debug_cmd_pkg::FLD_HI: begin
					data_q[`DBG_NB_BITS-1:HALF] <= payload;   // upper half only
				end
				debug_cmd_pkg::FLD_ADDR: begin
					addr_q <= payload[`DBG_RAM_DEPTH-1:0];   // low bits give the index
				end
				default: begin
					addr_q <= addr_q;   // FLD_NONE leaves both registers
				end
			endcase
		end
	end

	// write port driven from the registers before the edge
	assign probe.ram_addr = addr_q;
	assign probe.ram_data = data_q;
	assign probe.ram_we   = i_cmd[`DBG_BIT_WE] & i_in_use;   // only while halted

	// zero latency readback
	always_comb begin
		case (rd_sel)
			debug_cmd_pkg::RD_PC:         o_rd_data = probe.pc;
			debug_cmd_pkg::RD_PC_LATCH:   o_rd_data = probe.latch[`DBG_NB_BITS-1:0];
			debug_cmd_pkg::RD_INST_LATCH: o_rd_data = probe.latch[2*`DBG_NB_BITS-1:`DBG_NB_BITS];
			default:                      o_rd_data = i_cycles;   // RD_CYCLES
		endcase
	end

	// a memory write must carry a known address and word
	a_we_known : assert property (
		@(posedge i_clk) disable iff (i_rst)
		probe.ram_we |-> !$isunknown({probe.ram_addr, probe.ram_data})
	) else $error("ram write with unknown address or data");

endmodule

/* verilog/debug_control_fsm.sv */
`timescale 1ns/1ps

`include "debug_defs.svh"

module debug_control_fsm (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_cmd_strobe,   // new host word
	input  debug_cmd_pkg::run_ctl_t    i_run_ctl,      // valid with strobe
	input  debug_core_pkg::word_t      i_fetch_word,   // memory at pc
	output logic                       o_advance,      // fetch stage moves on
	output logic                       o_halted        // host owns the core
);

	debug_core_pkg::ctrl_state_t state_q;
	debug_core_pkg::ctrl_state_t state_d;
	logic                        at_halt;   // pc sits on the halt word
	logic                        do_run;
	logic                        do_step;
	logic                        do_halt;

	assign at_halt = (i_fetch_word == `DBG_HALT_WORD);
	assign do_run  = i_cmd_strobe && (i_run_ctl == debug_cmd_pkg::CTL_RUN);
	assign do_step = i_cmd_strobe && (i_run_ctl == debug_cmd_pkg::CTL_STEP);
	assign do_halt = i_cmd_strobe && (i_run_ctl == debug_cmd_pkg::CTL_HALT);

	always_comb begin
		state_d = state_q;   // hold by default
		case (state_q)
			debug_core_pkg::HALTED: begin
				if (do_run) begin
					state_d = debug_core_pkg::RUN;
				end else if (do_step) begin
					state_d = debug_core_pkg::STEP;
				end
			end
			debug_core_pkg::RUN: begin
				if (do_halt || at_halt) begin
					state_d = debug_core_pkg::HALTED;   // host stop or halt word
				end
			end
			debug_core_pkg::STEP: begin
				state_d = debug_core_pkg::HALTED;   // one cycle only
			end
			default: begin
				state_d = debug_core_pkg::HALTED;   // unused encoding
			end
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q <= debug_core_pkg::HALTED;
		end else begin
			state_q <= state_d;
		end
	end

	// no advance while the pc sits on the halt word
	assign o_halted  = (state_q == debug_core_pkg::HALTED);
	assign o_advance = !o_halted && !at_halt;

	// advancing starts one cycle after a run or step strobe
	a_adv_after_strobe : assert property (
		@(posedge i_clk) disable iff (i_rst)
		$rose(o_advance) |-> $past(i_cmd_strobe)
	) else $error("advance started without a host strobe");

endmodule

/* verilog/cycle_counter.sv */
`timescale 1ns/1ps

`include "debug_defs.svh"

module cycle_counter #(
	parameter int NB_CNT = `DBG_NB_BITS   // counter width
) (
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_clear,     // host clear, wins over count
	input  logic              i_advance,   // one per fetch advance
	output logic [NB_CNT-1:0] o_cycles
);

	logic [NB_CNT-1:0] cnt_q;
	logic              at_max;   // stick at all ones

	assign at_max = &cnt_q;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			cnt_q <= '0;
		end else if (i_clear) begin
			cnt_q <= '0;   // clear beats an advance in the same cycle
		end else if (i_advance && !at_max) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign o_cycles = cnt_q;

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

`include "debug_defs.svh"

module fetch_stage (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic                    i_advance,     // latch and bump pc
	debug_probe_if.target           probe,
	output debug_core_pkg::word_t   o_fetch_word   // async read at pc
);

	localparam int MEM_WORDS = 1 << `DBG_RAM_DEPTH;

	debug_core_pkg::word_t     mem [MEM_WORDS];   // program memory
	debug_core_pkg::word_t     pc_q;
	debug_core_pkg::latch_t    latch_q;           // {inst, pc}
	debug_core_pkg::ram_addr_t rd_addr;

	// host write port, the only way in
	always_ff @(posedge i_clk) begin
		if (probe.ram_we) begin
			mem[probe.ram_addr] <= probe.ram_data;
		end
	end

	assign rd_addr      = pc_q[`DBG_RAM_DEPTH-1:0];   // pc wraps on the array
	assign o_fetch_word = mem[rd_addr];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			pc_q    <= '0;
			latch_q <= '0;
		end else if (i_advance) begin
			latch_q <= {o_fetch_word, pc_q};   // word and where it came from
			pc_q    <= pc_q + 1'b1;
		end
	end

	assign probe.pc    = pc_q;
	assign probe.latch = latch_q;

	// write needs halted, advance needs running
	a_no_we_on_adv : assert property (
		@(posedge i_clk) disable iff (i_rst)
		!(probe.ram_we && i_advance)
	) else $error("ram write during fetch advance");

endmodule

/* verilog/debug_unit_top.sv */
`timescale 1ns/1ps

`include "debug_defs.svh"

module debug_unit_top (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic [`DBG_NB_BITS-1:0]  i_cmd,          // host word, held as a level
	input  logic                     i_cmd_strobe,   // one cycle, new word
	output logic [`DBG_NB_BITS-1:0]  o_rd_data,      // probe readback
	output logic                     o_running
);

	debug_cmd_pkg::run_ctl_t run_ctl;
	logic                    cnt_clear;
	logic                    advance;
	logic                    halted;
	debug_core_pkg::word_t   fetch_word;
	debug_core_pkg::word_t   cycles;

	debug_probe_if probe_bus ();   // loader to fetch stage

	// strobe only fields
	assign run_ctl   = debug_cmd_pkg::run_ctl_t'(i_cmd[`DBG_CTL_HI:`DBG_CTL_LO]);
	assign cnt_clear = i_cmd_strobe & i_cmd[`DBG_BIT_CLR];

	spi_fetch_interface loader_i (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_cmd     (i_cmd),
		.i_in_use  (halted),   // memory free only while halted
		.i_cycles  (cycles),
		.probe     (probe_bus.loader),
		.o_rd_data (o_rd_data)
	);

	debug_control_fsm ctrl_i (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cmd_strobe (i_cmd_strobe),
		.i_run_ctl    (run_ctl),
		.i_fetch_word (fetch_word),
		.o_advance    (advance),
		.o_halted     (halted)
	);

	cycle_counter #(
		.NB_CNT (`DBG_NB_BITS)
	) cycles_i (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_clear   (cnt_clear),
		.i_advance (advance),
		.o_cycles  (cycles)
	);

	fetch_stage fetch_i (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_advance    (advance),
		.probe        (probe_bus.target),
		.o_fetch_word (fetch_word)
	);

	assign o_running = !halted;

endmodule

/* bench/debug_unit_checker.sv */
`timescale 1ns/1ps

`include "debug_defs.svh"

module debug_unit_checker (
	input  logic                    i_clk,
	input  logic                    i_rst,
	input  logic [`DBG_NB_BITS-1:0] i_cmd,          // as seen by the dut
	input  logic                    i_cmd_strobe,
	input  logic [`DBG_NB_BITS-1:0] i_rd_data,
	input  logic                    i_running,
	input  logic                    i_check,        // readback case in progress
	input  logic [`DBG_NB_BITS-1:0] i_exp_word,     // value from the case file
	input  int                      i_case_idx,     // 0 before the first case
	output int                      o_errors,
	output int                      o_checks,
	output int                      o_cases_ok,
	output int                      o_cases_bad
);

	localparam int                      HALF = `DBG_NB_BITS / 2;
	localparam logic [`DBG_NB_BITS-1:0] ONES = `DBG_HALT_WORD;

	logic [`DBG_NB_BITS-1:0]     m_mem [1 << `DBG_RAM_DEPTH];   // memory model
	logic [`DBG_NB_BITS-1:0]     m_pc;
	logic [`DBG_NB_BITS-1:0]     m_lpc;     // latched pc
	logic [`DBG_NB_BITS-1:0]     m_linst;   // latched word
	logic [`DBG_NB_BITS-1:0]     m_cnt;
	logic [`DBG_NB_BITS-1:0]     m_data;    // assembled data register
	logic [`DBG_RAM_DEPTH-1:0]   m_addr;
	debug_core_pkg::ctrl_state_t m_state;
	logic [`DBG_NB_BITS-1:0]     m_fetch;
	logic                        m_adv;
	logic [1:0]                  ctl;
	logic [`DBG_NB_BITS-1:0]     want;
	int                          case_errs;
	int                          prev_idx;

	initial begin
		o_errors    = 0;
		o_checks    = 0;
		o_cases_ok  = 0;
		o_cases_bad = 0;
		case_errs   = 0;
		prev_idx    = 0;
	end

	assign m_fetch = m_mem[m_pc[`DBG_RAM_DEPTH-1:0]];
	assign ctl     = i_cmd[`DBG_CTL_HI:`DBG_CTL_LO];
	assign m_adv   = (m_state != debug_core_pkg::HALTED) && (m_fetch != ONES);   // halt word parks

	// reference model, one step per edge from the inputs before the edge
	always @(posedge i_clk) begin
		if (i_rst) begin
			m_pc    <= '0;
			m_lpc   <= '0;
			m_linst <= '0;
			m_cnt   <= '0;
			m_data  <= '0;
			m_addr  <= '0;
			m_state <= debug_core_pkg::HALTED;
		end else begin
			case (i_cmd[`DBG_FLD_HI:`DBG_FLD_LO])
				2'b01: m_data[HALF-1:0] <= i_cmd[HALF-1:0];
				2'b10: m_data[`DBG_NB_BITS-1:HALF] <= i_cmd[HALF-1:0];
				2'b11: m_addr <= i_cmd[`DBG_RAM_DEPTH-1:0];
			endcase
			if (i_cmd[`DBG_BIT_WE] && m_state == debug_core_pkg::HALTED) begin
				m_mem[m_addr] <= m_data;   // old address and data
			end
			if (m_adv) begin
				m_linst <= m_fetch;
				m_lpc   <= m_pc;
				m_pc    <= m_pc + 1;
			end
			if (i_cmd_strobe && i_cmd[`DBG_BIT_CLR]) begin
				m_cnt <= '0;   // clear wins
			end else if (m_adv && m_cnt != ONES) begin
				m_cnt <= m_cnt + 1;
			end
			case (m_state)
				debug_core_pkg::HALTED: begin
					if (i_cmd_strobe && ctl == debug_cmd_pkg::CTL_RUN) begin
						m_state <= debug_core_pkg::RUN;
					end else if (i_cmd_strobe && ctl == debug_cmd_pkg::CTL_STEP) begin
						m_state <= debug_core_pkg::STEP;
					end
				end
				debug_core_pkg::RUN: begin
					if ((i_cmd_strobe && ctl == debug_cmd_pkg::CTL_HALT) || m_fetch == ONES) begin
						m_state <= debug_core_pkg::HALTED;
					end
				end
				default: m_state <= debug_core_pkg::HALTED;   // step lasts one cycle
			endcase
		end
	end

	task automatic count_error();
		o_errors++;
		case_errs++;
	endtask

	task automatic report_case(input int idx);
		if (case_errs == 0) begin
			$display("case %0d ok", idx);
			o_cases_ok++;
		end else begin
			$display("case %0d FAILED with %0d mismatches", idx, case_errs);
			o_cases_bad++;
		end
		case_errs = 0;
	endtask

	// compare away from the rising edge
	always @(negedge i_clk) begin
		if (!i_rst) begin
			if (i_case_idx != prev_idx) begin
				if (prev_idx != 0) begin
					report_case(prev_idx);   // previous case just finished
				end
				prev_idx = i_case_idx;
			end
			if (i_running !== (m_state != debug_core_pkg::HALTED)) begin
				$display("ERROR @%0t: o_running is %b, model expects %b", $time, i_running,
					m_state != debug_core_pkg::HALTED);
				count_error();
			end
			if (i_check) begin
				case (i_cmd[`DBG_RD_HI:`DBG_RD_LO])
					2'b00:   want = m_pc;
					2'b01:   want = m_lpc;
					2'b10:   want = m_linst;
					default: want = m_cnt;
				endcase
				o_checks++;
				if (i_rd_data !== want) begin
					$display("ERROR @%0t: case %0d readback %h, model expects %h", $time,
						i_case_idx, i_rd_data, want);
					count_error();
				end
				if (i_rd_data !== i_exp_word) begin
					$display("ERROR @%0t: case %0d readback %h, case file expects %h", $time,
						i_case_idx, i_rd_data, i_exp_word);
					count_error();
				end
			end
		end
	end

endmodule

/* bench/debug_unit_tb.sv */
`timescale 1ns/1ps

`include "debug_defs.svh"

module debug_unit_tb;

	localparam int          CLK_HALF  = 10;     // 20 ns period
	localparam int          MAX_CASES = 64;
	localparam logic [31:0] ACT_READ  = 32'h3;
	localparam logic [31:0] ACT_RLOAD = 32'h8;  // low half payload from $random
	localparam logic [31:0] ACT_WAIT  = 32'h9;  // hold until the core halts

	logic                    clk;
	logic                    rst;
	logic [`DBG_NB_BITS-1:0] cmd;
	logic                    cmd_strobe;
	logic [`DBG_NB_BITS-1:0] rd_data;
	logic                    running;
	logic                    do_check;
	logic [`DBG_NB_BITS-1:0] exp_word;
	int                      case_idx;
	int                      errors;
	int                      checks;
	int                      cases_ok;
	int                      cases_bad;
	int                      n_cases;
	int                      run_fails;   // core never halted
	int                      watch_ns = 0;
	integer                  seed;
	logic [31:0]             case_mem [4*MAX_CASES];   // 4 words per case

	debug_unit_top dut_i (
		.i_clk        (clk),
		.i_rst        (rst),
		.i_cmd        (cmd),
		.i_cmd_strobe (cmd_strobe),
		.o_rd_data    (rd_data),
		.o_running    (running)
	);

	debug_unit_checker checker_i (
		.i_clk        (clk),
		.i_rst        (rst),
		.i_cmd        (cmd),
		.i_cmd_strobe (cmd_strobe),
		.i_rd_data    (rd_data),
		.i_running    (running),
		.i_check      (do_check),
		.i_exp_word   (exp_word),
		.i_case_idx   (case_idx),
		.o_errors     (errors),
		.o_checks     (checks),
		.o_cases_ok   (cases_ok),
		.o_cases_bad  (cases_bad)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_HALF) clk = ~clk;
	end

	// limit from the summed hold lengths, set once the cases are read
	initial begin
		wait (watch_ns > 0);
		#(watch_ns);
		$display("timeout: simulation still running after %0d ns", watch_ns);
		$display("Test failed");
		$finish;
	end

	task automatic load_cases();
		int total;
		total   = 0;
		n_cases = 0;
		$readmemh("bench/debug_cases.txt", case_mem);
		while (n_cases < MAX_CASES && !$isunknown(case_mem[4*n_cases])
				&& case_mem[4*n_cases] != 0) begin   // action 0 ends the list
			total += case_mem[4*n_cases+2];
			n_cases++;
		end
		if (n_cases == 0) begin
			$display("no cases found in bench/debug_cases.txt");
		end
		watch_ns = (total + 2 * n_cases + 30) * 2 * CLK_HALF;
	endtask

	task automatic wait_for_halt(input int idx, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (running && n < limit) begin
			@(posedge clk);
			cmd_strobe <= 1'b0;
			@(negedge clk);
			n++;
		end
		if (running) begin
			$display("case %0d: core did not halt within %0d cycles", idx, limit);
			run_fails++;
		end
	endtask

	task automatic run_case(input int idx);
		logic [31:0] act;
		logic [31:0] word;
		logic [31:0] hold;
		logic [31:0] rnd;
		act  = case_mem[4*(idx-1)];
		word = case_mem[4*(idx-1)+1];
		hold = case_mem[4*(idx-1)+2];
		if (hold == 0) begin
			hold = 1;
		end
		if (act == ACT_RLOAD) begin
			rnd        = $random(seed);
			word[15:0] = rnd[15:0];   // field code stays
		end
		@(posedge clk);
		cmd        <= word;
		cmd_strobe <= 1'b1;   // every case is a new word
		do_check   <= (act == ACT_READ);
		exp_word   <= case_mem[4*(idx-1)+3];
		case_idx   <= idx;
		if (act == ACT_WAIT) begin
			wait_for_halt(idx, hold);
		end else begin
			repeat (hold - 1) begin
				@(posedge clk);
				cmd_strobe <= 1'b0;   // word held as a level
			end
		end
	endtask

	initial begin
		rst        = 1'b1;
		cmd        = '0;
		cmd_strobe = 1'b0;
		do_check   = 1'b0;
		exp_word   = '0;
		case_idx   = 0;
		run_fails  = 0;
		seed       = 53355;
		load_cases();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (int i = 1; i <= n_cases; i++) begin
			run_case(i);
		end
		@(posedge clk);
		cmd        <= '0;
		cmd_strobe <= 1'b0;
		do_check   <= 1'b0;
		case_idx   <= n_cases + 1;   // lets the checker close the last case
		@(negedge clk);
		@(posedge clk);
		$display("cases %0d, ok %0d, failed %0d, readbacks %0d, errors %0d, run timeouts %0d",
			n_cases, cases_ok, cases_bad, checks, errors, run_fails);
		if (errors == 0 && cases_bad == 0 && run_fails == 0 && n_cases > 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* bench/debug_cases.txt */
// columns: action, command word, hold cycles (limit for wait), expected readback, all hex
// action 1 load, 2 write, 3 read, 4 run, 5 step, 6 halt, 7 clear, 8 random low load, 9 wait
3 00000000 1 00000000
3 00010000 1 00000000
3 00020000 1 00000000
3 00030000 1 00000000
1 0008ABCD 2 00000000
1 00101234 1 00000000
1 00180000 1 00000000
2 00400000 1 00000000
1 0008FFEE 1 00000000
1 001000C0 2 00000000
1 00180001 1 00000000
2 00400000 1 00000000
1 0008F00D 1 00000000
1 00180002 1 00000000
2 00400000 2 00000000
1 0008FFFF 1 00000000
1 0010FFFF 1 00000000
1 00180003 1 00000000
2 00400000 1 00000000
5 01000000 3 00000000
3 00020000 1 1234ABCD
3 00010000 1 00000000
3 00000000 1 00000001
7 00200000 1 00000000
4 00800000 1 00000000
9 00000000 10 00000000
3 00030000 1 00000002
3 00000000 1 00000003
3 00020000 1 00C0F00D
1 00101111 1 00000000
8 00080000 1 00000000
4 00800000 1 00000000
2 00400000 1 00000000
9 00000000 4 00000000
5 01000000 3 00000000
3 00000000 1 00000003
3 00020000 1 00C0F00D
6 01800000 2 00000000
7 00200000 1 00000000
3 00030000 1 00000000
0 00000000 0 00000000

/* debug_unit_top.f */
+incdir+verilog
verilog/debug_cmd_pkg.sv
verilog/debug_core_pkg.sv
verilog/debug_probe_if.sv
verilog/spi_fetch_interface.sv
verilog/debug_control_fsm.sv
verilog/cycle_counter.sv
verilog/fetch_stage.sv
verilog/debug_unit_top.sv
bench/debug_unit_checker.sv
bench/debug_unit_tb.sv

/* Bender.yml */
package:
  name: debug_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/debug_cmd_pkg.sv
      - verilog/debug_core_pkg.sv
      - verilog/debug_probe_if.sv
      - verilog/spi_fetch_interface.sv
      - verilog/debug_control_fsm.sv
      - verilog/cycle_counter.sv
      - verilog/fetch_stage.sv
      - verilog/debug_unit_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/debug_unit_checker.sv
      - bench/debug_unit_tb.sv
